// ==== verilog.f ====
source/mdu_pkg.sv
source/mdu_operand_prep.sv
source/mdu_control.sv
source/mdu_divider.sv
source/mdu_multiplier.sv
source/mdu_result_sel.sv
source/mdu_top.sv
testbench/mdu_properties.sv
testbench/mdu_tb.sv

// ==== Makefile ====
SIM      = verilator
VFLAGS   = --binary --timing --assert -j 0
TOP      = mdu_tb
FILELIST = verilog.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation completed successfully

.PHONY: sim clean

# The run passes only if the pass line shows up in the simulator output
sim:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /$(PASS_MSG)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/mdu_stim.txt ====
# kind name op a b expected, with a, b and expected in hex
# run checks one result, flush aborts the request, restart flushes a decoy and sends it
run mul_small mul 0000000000000007 0000000000000006 000000000000002a
run mul_neg mul fffffffffffffffd 0000000000000005 fffffffffffffff1
run mul_wide mul 0000000100000000 0000000100000003 0000000300000000
run mulh_min_min mulh 8000000000000000 8000000000000000 4000000000000000
run mulh_max_max mulh 7fffffffffffffff 7fffffffffffffff 3fffffffffffffff
run mulh_min_max mulh 8000000000000000 7fffffffffffffff c000000000000000
run mulhsu_neg mulhsu ffffffffffffffff ffffffffffffffff ffffffffffffffff
run mulhsu_pos mulhsu 0000000000000002 ffffffffffffffff 0000000000000001
run mulhu_max mulhu ffffffffffffffff ffffffffffffffff fffffffffffffffe
run mulhu_wide mulhu 0000000100000000 0000000100000003 0000000000000001
run div_pos div 0000000000000014 0000000000000006 0000000000000003
run div_neg_a div ffffffffffffffec 0000000000000006 fffffffffffffffd
run div_neg_b div 0000000000000014 fffffffffffffffa fffffffffffffffd
run div_neg_both div ffffffffffffffec fffffffffffffffa 0000000000000003
run rem_neg_a rem ffffffffffffffec 0000000000000006 fffffffffffffffe
flush div_flushed div 0000000000000014 0000000000000006 0000000000000000
run rem_neg_b rem 0000000000000014 fffffffffffffffa 0000000000000002
run rem_neg_both rem ffffffffffffffec fffffffffffffffa fffffffffffffffe
run divu_big divu ffffffffffffffec 0000000000000006 2aaaaaaaaaaaaaa7
run remu_big remu ffffffffffffffec 0000000000000006 0000000000000002
run div_min_half div 8000000000000000 0000000000000002 c000000000000000
restart mulhu_restart mulhu ffffffffffffffff ffffffffffffffff fffffffffffffffe
run div_zero div 0000000000000014 0000000000000000 ffffffffffffffff
run divu_zero divu 0000000000000014 0000000000000000 ffffffffffffffff
run rem_zero rem ffffffffffffffec 0000000000000000 ffffffffffffffec
run remu_zero remu 0000000000001234 0000000000000000 0000000000001234
flush mul_flushed mulhu ffffffffffffffff ffffffffffffffff 0000000000000000
run div_ovf div 8000000000000000 ffffffffffffffff 8000000000000000
run rem_ovf rem 8000000000000000 ffffffffffffffff 0000000000000000
restart rem_restart rem ffffffffffffffec 0000000000000006 fffffffffffffffe
run divu_min divu 8000000000000000 ffffffffffffffff 0000000000000000

// ==== testbench/mdu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mdu_tb
    import mdu_pkg::*;
();

    localparam int latency      = 66;
    localparam int cycle_budget = 80;

    logic      clk;
    logic      rst;
    logic      in_valid;
    logic      flush;
    mdu_req_t  req;
    logic      ready;
    logic      out_valid;
    mdu_resp_t resp;

    string     kind_q[$];
    string     name_q[$];
    mdu_op_e   op_q[$];
    mdu_word_t a_q[$];
    mdu_word_t b_q[$];
    mdu_word_t exp_q[$];
    int        vec_count;
    bit        passed;
    bit        reported;

    mdu_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .flush     (flush),
        .req       (req),
        .ready     (ready),
        .out_valid (out_valid),
        .resp      (resp)
    );

    bind mdu_top mdu_properties props0 (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .start     (start),
        .ready     (ready),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic abort_run();
        reported = 1'b1;
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_resp(input string name, input mdu_resp_t exp, input mdu_resp_t act);
        if (act !== exp) begin
            $display("Error: %s expected %h actual %h", name, exp.result, act.result);
            abort_run();
        end
    endtask

    task automatic check_ready(input logic exp, input string where);
        if (ready !== exp) begin
            $display("ready is %b %s but should be %b", ready, where, exp);
            abort_run();
        end
    endtask

    task automatic check_latency(input string name, input int act);
        if (act != latency) begin
            $display("Error: %s expected latency %0d actual %0d", name, latency, act);
            abort_run();
        end
    endtask

    function automatic mdu_op_e op_from_name(input string s, output logic ok);
        mdu_op_e e;
        int      i;
        e  = e.first();
        ok = 1'b0;
        for (i = 0; i < e.num(); i++) begin
            if (e.name() == {"mdu_op_", s}) begin
                ok = 1'b1;
                return e;
            end
            e = e.next();
        end
        return mdu_op_mul;
    endfunction

    task automatic load_vectors();
        int        fd;
        int        n;
        string     line;
        string     kind;
        string     name;
        string     op_name;
        mdu_word_t a;
        mdu_word_t b;
        mdu_word_t exp;
        logic      ok;
        fd = $fopen("testbench/mdu_stim.txt", "r");
        if (fd == 0) begin
            $display("The vector file testbench/mdu_stim.txt cannot be opened");
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            // Skip comments and blank lines
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %s %s %h %h %h", kind, name, op_name, a, b, exp);
            if (n != 6) begin
                $display("A line of the vector file has the wrong format: %s", line);
                abort_run();
            end
            op_q.push_back(op_from_name(op_name, ok));
            if (!ok) begin
                $display("Vector %s names an unknown operation %s", name, op_name);
                abort_run();
            end
            kind_q.push_back(kind);
            name_q.push_back(name);
            a_q.push_back(a);
            b_q.push_back(b);
            exp_q.push_back(exp);
        end
        $fclose(fd);
        vec_count = kind_q.size();
        if (vec_count == 0) begin
            $display("The vector file testbench/mdu_stim.txt holds no vectors");
            abort_run();
        end
    endtask

    // Random request contents while in_valid is low
    task automatic drive_idle();
        logic [31:0] rnd;
        rnd      = $urandom;
        in_valid = 1'b0;
        flush    = 1'b0;
        req.op   = mdu_op_e'(rnd[2:0]);
        req.a    = {$urandom, $urandom};
        req.b    = {$urandom, $urandom};
    endtask

    task automatic idle_gap(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            drive_idle();
        end
    endtask

    // Returns just after the accepting edge
    task automatic send_req(input mdu_op_e op, input mdu_word_t a, input mdu_word_t b,
                            input logic with_flush);
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        flush    = with_flush;
        req.op   = op;
        req.a    = a;
        req.b    = b;
        @(negedge clk);
        if (!with_flush) begin
            check_ready(1'b1, "before a request");
        end
        @(posedge clk);
        #2;
        drive_idle();
    endtask

    task automatic collect_result(input int i);
        int        cycles;
        mdu_resp_t exp;
        cycles     = 0;
        exp.result = exp_q[i];
        @(negedge clk);
        while (out_valid !== 1'b1) begin
            check_ready(1'b0, {"while ", name_q[i], " is busy"});
            if (cycles > latency + 10) begin
                $display("No result arrived for %s", name_q[i]);
                abort_run();
            end
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        check_latency(name_q[i], cycles);
        check_resp(name_q[i], exp, resp);
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            $display("out_valid for %s lasted more than one cycle", name_q[i]);
            abort_run();
        end
        check_ready(1'b1, {"after the result of ", name_q[i]});
    endtask

    task automatic flush_vector(input int i);
        int k;
        k = $urandom % 16 + 5;
        send_req(op_q[i], a_q[i], b_q[i], 1'b0);
        repeat (k) @(posedge clk);
        #2;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        @(negedge clk);
        check_ready(1'b1, {"after the flush of ", name_q[i]});
        repeat (latency - k) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("A result appeared for the flushed operation %s", name_q[i]);
                abort_run();
            end
        end
    endtask

    // A decoy request is aborted by a flush that carries the real one
    task automatic restart_vector(input int i);
        int          k;
        logic [31:0] rnd;
        k   = $urandom % 16 + 5;
        rnd = $urandom;
        send_req(mdu_op_e'(rnd[2:0]), {$urandom, $urandom}, {$urandom, $urandom}, 1'b0);
        repeat (k) @(posedge clk);
        send_req(op_q[i], a_q[i], b_q[i], 1'b1);
        collect_result(i);
    endtask

    initial begin
        longint limit;
        wait (vec_count > 0);
        limit = (longint'(vec_count) * cycle_budget + 8) * 20;
        #(limit);
        $display("Timeout: the tests did not finish within %0d ns", limit);
        abort_run();
    end

    initial begin
        int i;
        void'($urandom(32'ha90));
        passed    = 1'b0;
        reported  = 1'b0;
        vec_count = 0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        flush     = 1'b0;
        req       = '0;
        load_vectors();
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_ready(1'b1, "after reset");
        if (out_valid !== 1'b0) begin
            $display("out_valid is high after reset");
            abort_run();
        end
        for (i = 0; i < vec_count; i++) begin
            idle_gap($urandom % 4 + 1);
            if (kind_q[i] == "run") begin
                send_req(op_q[i], a_q[i], b_q[i], 1'b0);
                collect_result(i);
            end else if (kind_q[i] == "flush") begin
                flush_vector(i);
            end else if (kind_q[i] == "restart") begin
                restart_vector(i);
            end else begin
                $display("Vector %s has an unknown kind %s", name_q[i], kind_q[i]);
                abort_run();
            end
        end
        passed = 1'b1;
        $display("Simulation completed successfully");
        $finish;
    end

    // Covers runs stopped by a failing assertion
    final begin
        if (!passed && !reported) begin
            $display("Simulation failed");
        end
    end

endmodule

`default_nettype wire

// ==== testbench/mdu_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module mdu_properties (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic start,
    input logic ready,
    input logic out_valid
);

    localparam int latency = 66;

    logic       in_flight;
    logic [6:0] age;

    // Operation in flight and the edges seen since it was accepted
    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= 1'b0;
            age       <= '0;
        end else if (start) begin
            in_flight <= 1'b1;
            age       <= '0;
        end else if (flush || out_valid) begin
            in_flight <= 1'b0;
            age       <= '0;
        end else if (in_flight) begin
            age <= age + 7'd1;
        end
    end

    single_pulse: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid)
        else $error("out_valid stayed high for two cycles");

    ready_low_busy: assert property (@(posedge clk) disable iff (rst)
        in_flight |-> !ready)
        else $error("ready high while an operation is in flight");

    no_early_result: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> (in_flight && (age == 7'(latency))))
        else $error("out_valid at the wrong cycle after acceptance");

    result_on_time: assert property (@(posedge clk) disable iff (rst)
        (in_flight && (age == 7'(latency)) && !flush) |-> out_valid)
        else $error("out_valid missing at the expected cycle");

endmodule

`default_nettype wire

// ==== source/mdu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mdu_top
    import mdu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  logic      flush,
    input  mdu_req_t  req,
    output logic      ready,
    output logic      out_valid,
    output mdu_resp_t resp
);

    logic                  start;
    logic                  resp_valid;
    mdu_prep_t             prep;
    logic                  div_done;
    logic                  mul_done;
    mdu_word_t             quot_mag;
    mdu_word_t             rem_mag;
    logic [2*mdu_xlen-1:0] prod_mag;

    mdu_control u_control (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .flush      (flush),
        .ready      (ready),
        .start      (start),
        .out_valid  (out_valid),
        .resp_valid (resp_valid)
    );

    mdu_operand_prep u_operand_prep (
        .req  (req),
        .prep (prep)
    );

    // Only the engine picked by the decode runs
    mdu_divider u_divider (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .flush    (flush),
        .enable   (prep.is_div),
        .mag_a    (prep.mag_a),
        .mag_b    (prep.mag_b),
        .done     (div_done),
        .quot_mag (quot_mag),
        .rem_mag  (rem_mag)
    );

    mdu_multiplier u_multiplier (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .flush    (flush),
        .enable   (~prep.is_div),
        .mag_a    (prep.mag_a),
        .mag_b    (prep.mag_b),
        .done     (mul_done),
        .prod_mag (prod_mag)
    );

    mdu_result_sel u_result_sel (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .flush      (flush),
        .div_done   (div_done),
        .mul_done   (mul_done),
        .prep       (prep),
        .quot_mag   (quot_mag),
        .rem_mag    (rem_mag),
        .prod_mag   (prod_mag),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

`default_nettype wire

// ==== source/mdu_result_sel.sv ====
`timescale 1ns/1ns
`default_nettype none

module mdu_result_sel
    import mdu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  flush,
    input  logic                  div_done,
    input  logic                  mul_done,
    input  mdu_prep_t             prep,
    input  mdu_word_t             quot_mag,
    input  mdu_word_t             rem_mag,
    input  logic [2*mdu_xlen-1:0] prod_mag,
    output logic                  resp_valid,
    output mdu_resp_t             resp
);

    mdu_prep_t             prep_q;
    logic                  done;
    logic [2*mdu_xlen-1:0] prod_fix;
    mdu_word_t             quot_fix;
    mdu_word_t             rem_fix;
    mdu_word_t             result;

    // Decode of the operation in flight
    always_ff @(posedge clk) begin
        if (start) begin
            prep_q <= prep;
        end
    end

    assign done = prep_q.is_div ? div_done : mul_done;

    // Two's-complement sign correction of the unsigned engine results
    assign prod_fix = prep_q.neg_result ? (~prod_mag + 1'b1) : prod_mag;
    assign quot_fix = prep_q.neg_result ? (~quot_mag + 1'b1) : quot_mag;
    assign rem_fix  = prep_q.neg_result ? (~rem_mag + 1'b1) : rem_mag;

    always_comb begin
        case (prep_q.op)
            mdu_op_mul: result = prod_fix[mdu_xlen-1:0];
            mdu_op_mulh, mdu_op_mulhsu, mdu_op_mulhu: begin
                result = prod_fix[2*mdu_xlen-1:mdu_xlen];
            end
            mdu_op_div, mdu_op_divu: begin
                if (prep_q.div_by_zero) begin
                    result = '1;
                end else if (prep_q.overflow) begin
                    result = {1'b1, {(mdu_xlen-1){1'b0}}};
                end else begin
                    result = quot_fix;
                end
            end
            default: begin
                // rem and remu
                if (prep_q.div_by_zero) begin
                    result = prep_q.a_orig;
                end else if (prep_q.overflow) begin
                    result = '0;
                end else begin
                    result = rem_fix;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= done && !flush && !start;
        end
    end

    // Held until the next result
    always_ff @(posedge clk) begin
        if (done && !flush) begin
            resp.result <= result;
        end
    end

endmodule

`default_nettype wire

// ==== source/mdu_multiplier.sv ====
`timescale 1ns/1ns
`default_nettype none

module mdu_multiplier
    import mdu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  flush,
    input  logic                  enable,
    input  mdu_word_t             mag_a,
    input  mdu_word_t             mag_b,
    output logic                  done,
    output logic [2*mdu_xlen-1:0] prod_mag
);

    localparam int cnt_w = $clog2(mdu_xlen + 1);

    logic [2*mdu_xlen-1:0] acc;
    logic [2*mdu_xlen-1:0] mcand;
    mdu_word_t             mplier;
    logic [cnt_w-1:0]      count;
    logic                  running;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            count   <= '0;
            done    <= 1'b0;
        end else if (start) begin
            running <= enable;
            count   <= '0;
            done    <= 1'b0;
        end else if (flush) begin
            running <= 1'b0;
            count   <= '0;
            done    <= 1'b0;
        end else if (running) begin
            if (count != cnt_w'(mdu_xlen)) begin
                count <= count + 1'b1;
                done  <= 1'b0;
            end else begin
                running <= 1'b0;
                count   <= '0;
                done    <= 1'b1;
            end
        end else begin
            done <= 1'b0;
        end
    end

    // Add the multiplicand for each set multiplier bit, LSB first
    always_ff @(posedge clk) begin
        if (start && enable) begin
            acc    <= '0;
            mcand  <= {{mdu_xlen{1'b0}}, mag_a};
            mplier <= mag_b;
        end else if (running && (count != cnt_w'(mdu_xlen))) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign prod_mag = acc;

endmodule

`default_nettype wire

// ==== source/mdu_divider.sv ====
`timescale 1ns/1ns
`default_nettype none

module mdu_divider
    import mdu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  logic      flush,
    input  logic      enable,
    input  mdu_word_t mag_a,
    input  mdu_word_t mag_b,
    output logic      done,
    output mdu_word_t quot_mag,
    output mdu_word_t rem_mag
);

    localparam int cnt_w = $clog2(mdu_xlen + 1);

    // Upper half holds the partial remainder, lower half collects quotient bits
    logic [2*mdu_xlen-1:0] rem_quot;
    logic [2*mdu_xlen-1:0] divisor_sh;
    logic [2*mdu_xlen:0]   shifted;
    logic [2*mdu_xlen-1:0] rem_quot_next;
    logic [cnt_w-1:0]      count;
    logic                  running;

    // One extra bit so the shifted remainder cannot wrap before the compare
    assign shifted = {rem_quot, 1'b0};

    always_comb begin
        if (shifted >= {1'b0, divisor_sh}) begin
            rem_quot_next = shifted[2*mdu_xlen-1:0] - divisor_sh + 1'b1;
        end else begin
            rem_quot_next = shifted[2*mdu_xlen-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            count   <= '0;
            done    <= 1'b0;
        end else if (start) begin
            running <= enable;
            count   <= '0;
            done    <= 1'b0;
        end else if (flush) begin
            running <= 1'b0;
            count   <= '0;
            done    <= 1'b0;
        end else if (running) begin
            if (count != cnt_w'(mdu_xlen)) begin
                count <= count + 1'b1;
                done  <= 1'b0;
            end else begin
                running <= 1'b0;
                count   <= '0;
                done    <= 1'b1;
            end
        end else begin
            done <= 1'b0;
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        if (start && enable) begin
            rem_quot   <= {{mdu_xlen{1'b0}}, mag_a};
            divisor_sh <= {mag_b, {mdu_xlen{1'b0}}};
        end else if (running && (count != cnt_w'(mdu_xlen))) begin
            rem_quot <= rem_quot_next;
        end
    end

    assign quot_mag = rem_quot[mdu_xlen-1:0];
    assign rem_mag  = rem_quot[2*mdu_xlen-1:mdu_xlen];

endmodule

`default_nettype wire

// ==== source/mdu_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module mdu_control (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  logic flush,
    output logic ready,
    output logic start,
    output logic out_valid,
    input  logic resp_valid
);

    logic busy;

    // A flush lets a new request in even while busy
    assign start = in_valid && (ready || flush);

    assign ready = ~busy;

    // Result of a flushed operation never leaves the unit
    assign out_valid = resp_valid && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (flush || out_valid) begin
            // Ready comes back on the edge after the result pulse
            busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/mdu_operand_prep.sv ====
`timescale 1ns/1ns
`default_nettype none

module mdu_operand_prep
    import mdu_pkg::*;
(
    input  mdu_req_t  req,
    output mdu_prep_t prep
);

    logic a_signed;
    logic b_signed;
    logic a_neg;
    logic b_neg;

    // Which operands are read as two's complement
    always_comb begin
        a_signed = 1'b0;
        b_signed = 1'b0;
        case (req.op)
            mdu_op_mulh, mdu_op_div, mdu_op_rem: begin
                a_signed = 1'b1;
                b_signed = 1'b1;
            end
            mdu_op_mulhsu: begin
                a_signed = 1'b1;
            end
            default: begin
                a_signed = 1'b0;
                b_signed = 1'b0;
            end
        endcase
    end

    assign a_neg = a_signed && req.a[mdu_xlen-1];
    assign b_neg = b_signed && req.b[mdu_xlen-1];

    always_comb begin
        prep.op     = req.op;
        prep.mag_a  = a_neg ? (~req.a + 1'b1) : req.a;
        prep.mag_b  = b_neg ? (~req.b + 1'b1) : req.b;
        prep.is_div = req.op[2];
        prep.a_orig = req.a;

        // Remainder follows the dividend, quotient and mulh follow both signs
        case (req.op)
            mdu_op_mulh, mdu_op_div: prep.neg_result = a_neg ^ b_neg;
            mdu_op_mulhsu, mdu_op_rem: prep.neg_result = a_neg;
            default: prep.neg_result = 1'b0;
        endcase

        prep.div_by_zero = req.op[2] && (req.b == '0);

        // Most negative value divided by minus one
        prep.overflow = ((req.op == mdu_op_div) || (req.op == mdu_op_rem))
                        && (req.a == {1'b1, {(mdu_xlen-1){1'b0}}})
                        && (req.b == '1);
    end

endmodule

`default_nettype wire

// ==== source/mdu_pkg.sv ====
`default_nettype none

package mdu_pkg;

    // Operand and result width of the core
    localparam int mdu_xlen = 64;

    typedef logic [mdu_xlen-1:0] mdu_word_t;

    // Values follow the funct3 field of the RV64M instructions
    typedef enum logic [2:0] {
        mdu_op_mul    = 3'd0,
        mdu_op_mulh   = 3'd1,
        mdu_op_mulhsu = 3'd2,
        mdu_op_mulhu  = 3'd3,
        mdu_op_div    = 3'd4,
        mdu_op_divu   = 3'd5,
        mdu_op_rem    = 3'd6,
        mdu_op_remu   = 3'd7
    } mdu_op_e;

    // Request from the issue stage; a is dividend or multiplicand
    typedef struct packed {
        mdu_op_e   op;
        mdu_word_t a;
        mdu_word_t b;
    } mdu_req_t;

    // Decoded request as seen by the engines and the result stage
    typedef struct packed {
        mdu_op_e   op;
        mdu_word_t mag_a;
        mdu_word_t mag_b;
        logic      neg_result;
        logic      is_div;
        logic      div_by_zero;
        logic      overflow;
        mdu_word_t a_orig;
    } mdu_prep_t;

    typedef struct packed {
        mdu_word_t result;
    } mdu_resp_t;

endpackage

`default_nettype wire
